/* hello_config.svh */
/*
   Widths and constants of the hello-world PCIe slave port
   Single 32-bit register, one access in flight, no bursts
   Lane bits select one 32-bit word of the 512-bit data bus
*/
`ifndef HELLO_CONFIG_SVH
`define HELLO_CONFIG_SVH

// --------------------------------------------------------------------
// PCIe slave port
// --------------------------------------------------------------------
`define PCIS_DATA_W    512
`define PCIS_ADDR_W    64
`define PCIS_ID_W      5
`define PCIS_STRB_W    (`PCIS_DATA_W / 8)

// Address bits that pick the 32-bit lane
`define LANE_SEL_LSB   2
`define LANE_SEL_MSB   5

// --------------------------------------------------------------------
// Config bus and register map
// --------------------------------------------------------------------
`define CFG_DATA_W     32
`define CFG_ADDR_W     8

`define HELLO_ADDR     8'h00
`define HELLO_RST_VAL  32'h0000_0000
`define CFG_BAD_RDATA  32'hffff_ffff

`endif

/* pcis_pkg.sv */
/*
   Types of the PCIe slave port and its controller
   Only the OKAY response is ever returned
*/
`include "hello_config.svh"

package pcis_pkg;

   // Slave controller states
   typedef enum logic [2:0]
   {
      SLV_IDLE    = 3'd0,
      SLV_WR_ADDR = 3'd1,
      SLV_CYC     = 3'd2,
      SLV_RESP    = 3'd3
   } slv_state_t;

   // AXI response codes
   typedef enum logic [1:0]
   {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } pcis_resp_t;

   typedef logic [`PCIS_DATA_W-1:0] pcis_data_t;
   typedef logic [`PCIS_ADDR_W-1:0] pcis_addr_t;
   typedef logic [`PCIS_ID_W-1:0]   pcis_id_t;

endpackage

/* cfg_pkg.sv */
/*
   Types of the internal config bus
   One command pulse per access, answered by a one-cycle ack
*/
`include "hello_config.svh"

package cfg_pkg;

   // Config bus opcodes
   typedef enum logic [1:0]
   {
      CFG_NOP = 2'd0,
      CFG_WR  = 2'd1,
      CFG_RD  = 2'd2
   } cfg_cmd_t;

   typedef logic [`CFG_DATA_W-1:0] cfg_data_t;
   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;

   // Register map
   localparam cfg_addr_t HELLO_REG = `HELLO_ADDR;

endpackage

/* pcis_wr_capture.sv */
/*
   Holds address and ID of the pending write
   The write word follows wdata combinationally, so wdata must stay
   valid until wready as the handshake requires
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module pcis_wr_capture
   import pcis_pkg::*, cfg_pkg::*;
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  logic       capture,
   input  pcis_addr_t awaddr,
   input  pcis_id_t   awid,
   input  pcis_data_t wdata,
   output pcis_addr_t wr_addr,
   output pcis_id_t   wr_id,
   output cfg_data_t  wr_word
);

   logic [`LANE_SEL_MSB-`LANE_SEL_LSB:0] wr_lane;

   // --------------------------------------------------------------------
   // Address and ID hold
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         wr_addr <= '0;
         wr_id   <= '0;
      end
      else if (capture)
      begin
         wr_addr <= awaddr;
         wr_id   <= awid;
      end
   end

   // --------------------------------------------------------------------
   // Lane extraction
   // --------------------------------------------------------------------
   assign wr_lane = wr_addr[`LANE_SEL_MSB:`LANE_SEL_LSB];

   // Pick the 32-bit word named by the held address
   assign wr_word = wdata[wr_lane*`CFG_DATA_W +: `CFG_DATA_W];

endmodule

/* pcis_rd_capture.sv */
/*
   Holds address and ID of the pending read
   Read data sits in the lane the read address names; all other
   lanes are zero
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module pcis_rd_capture
   import pcis_pkg::*, cfg_pkg::*;
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  logic       capture,
   input  pcis_addr_t araddr,
   input  pcis_id_t   arid,
   input  cfg_data_t  rd_word,
   output pcis_addr_t rd_addr,
   output pcis_id_t   rd_id,
   output pcis_data_t rdata
);

   logic [`LANE_SEL_MSB-`LANE_SEL_LSB:0] rd_lane;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         rd_addr <= '0;
         rd_id   <= '0;
      end
      else if (capture)
      begin
         rd_addr <= araddr;
         rd_id   <= arid;
      end
   end

   assign rd_lane = rd_addr[`LANE_SEL_MSB:`LANE_SEL_LSB];

   // Place the returned word, zero elsewhere
   always_comb
   begin
      rdata = '0;
      rdata[rd_lane*`CFG_DATA_W +: `CFG_DATA_W] = rd_word;
   end

endmodule

/* pcis_slave_fsm.sv */
/*
   Slave controller, one access in flight, write has fixed priority
   Issues a single config command per access and waits for its ack
   Response is held in SLV_RESP until bready or rready
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module pcis_slave_fsm
   import pcis_pkg::*, cfg_pkg::*;
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  logic       awvalid,
   input  logic       wvalid,
   input  logic       bready,
   input  logic       arvalid,
   input  logic       rready,
   input  pcis_addr_t wr_addr,
   input  pcis_addr_t rd_addr,
   input  cfg_data_t  wr_word,
   input  logic       cfg_ack,
   input  cfg_data_t  cfg_rdata,
   output logic       capture,
   output logic       awready,
   output logic       wready,
   output logic       arready,
   output logic       bvalid,
   output logic       rvalid,
   output pcis_resp_t bresp,
   output pcis_resp_t rresp,
   output cfg_data_t  rd_word,
   output cfg_data_t  cfg_wdata,
   output cfg_cmd_t   cfg_cmd,
   output cfg_addr_t  cfg_addr
);

   slv_state_t slv_state;
   slv_state_t slv_state_nxt;

   logic       cyc_wr;       // Current access is a write
   logic       did_req;      // Command already sent for this access
   logic       req_valid;
   logic       rsp_ready;
   logic       issue;
   pcis_addr_t mx_addr;

   assign capture   = (slv_state == SLV_IDLE) && (awvalid || arvalid);
   assign req_valid = cyc_wr ? wvalid : 1'b1;
   assign rsp_ready = cyc_wr ? bready : rready;
   assign mx_addr   = cyc_wr ? wr_addr : rd_addr;
   assign issue     = (slv_state == SLV_CYC) && req_valid && !did_req;

   // --------------------------------------------------------------------
   // Arbitration and state machine
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         cyc_wr <= 1'b0;
      else if (slv_state == SLV_IDLE)
         cyc_wr <= awvalid;
   end

   always_comb
   begin
      slv_state_nxt = slv_state;
      case (slv_state)
         SLV_IDLE:
         begin
            if (awvalid)
               slv_state_nxt = SLV_WR_ADDR;
            else if (arvalid)
               slv_state_nxt = SLV_CYC;
         end
         SLV_WR_ADDR:
            slv_state_nxt = SLV_CYC;
         SLV_CYC:
         begin
            if (cfg_ack)
               slv_state_nxt = SLV_RESP;
         end
         SLV_RESP:
         begin
            if (rsp_ready)
               slv_state_nxt = SLV_IDLE;
         end
         default:
            slv_state_nxt = SLV_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         slv_state <= SLV_IDLE;
      else
         slv_state <= slv_state_nxt;
   end

   // --------------------------------------------------------------------
   // Config command, one registered pulse per access
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         did_req <= 1'b0;
         cfg_cmd <= CFG_NOP;
      end
      else
      begin
         did_req <= (slv_state != SLV_IDLE) && (did_req || issue);
         if (issue)
            cfg_cmd <= cyc_wr ? CFG_WR : CFG_RD;
         else
            cfg_cmd <= CFG_NOP;
      end
   end

   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         cfg_addr  <= mx_addr[`CFG_ADDR_W-1:0];
         cfg_wdata <= wr_word;
      end
   end

   // Returned data is valid with the ack
   always_ff @(posedge clk)
   begin
      if (cfg_ack)
         rd_word <= cfg_rdata;
   end

   // --------------------------------------------------------------------
   // Handshake back to the host
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         awready <= 1'b0;
      else
         awready <= (slv_state_nxt == SLV_WR_ADDR);
   end

   // High in the last SLV_CYC cycle only
   assign wready  = (slv_state == SLV_CYC) && cfg_ack && cyc_wr;
   assign arready = (slv_state == SLV_CYC) && cfg_ack && !cyc_wr;

   assign bvalid = (slv_state == SLV_RESP) && cyc_wr;
   assign rvalid = (slv_state == SLV_RESP) && !cyc_wr;
   assign bresp  = RESP_OKAY;
   assign rresp  = RESP_OKAY;

endmodule

/* cfg_reg_block.sv */
/*
   Hello-world register behind the config bus
   Every write updates it, whatever the address
   Reads return it byte-reversed at HELLO_ADDR, all ones elsewhere
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module cfg_reg_block
   import cfg_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  cfg_cmd_t  cfg_cmd,
   input  cfg_addr_t cfg_addr,
   input  cfg_data_t cfg_wdata,
   output logic      cfg_ack,
   output cfg_data_t cfg_rdata
);

   cfg_cmd_t  cmd_q;
   cfg_addr_t addr_q;
   cfg_data_t wdata_q;
   cfg_data_t hello_q;

   // --------------------------------------------------------------------
   // Command capture, held until the ack goes out
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         cmd_q <= CFG_NOP;
      else if (cfg_cmd != CFG_NOP)
         cmd_q <= cfg_cmd;
      else if (cfg_ack)
         cmd_q <= CFG_NOP;
   end

   always_ff @(posedge clk)
   begin
      if (cfg_cmd != CFG_NOP)
      begin
         addr_q  <= cfg_addr;
         wdata_q <= cfg_wdata;
      end
   end

   // Two cycles after the command
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         cfg_ack <= 1'b0;
      else
         cfg_ack <= (cmd_q != CFG_NOP) && !cfg_ack;
   end

   // --------------------------------------------------------------------
   // Hello-world register and readback
   // --------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         hello_q <= `HELLO_RST_VAL;
      else if ((cmd_q == CFG_WR) && !cfg_ack)
         hello_q <= wdata_q;
   end

   always_ff @(posedge clk)
   begin
      case (addr_q)
         HELLO_REG:
            cfg_rdata <= {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
         default:
            cfg_rdata <= `CFG_BAD_RDATA;
      endcase
   end

endmodule

/* cl_hello_world.sv */
/*
   Hello-world custom logic with a single-beat PCIe slave port
   Write address and data must be presented together; no bursts
   wstrb is ignored and rlast is always high
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module cl_hello_world
   import pcis_pkg::*, cfg_pkg::*;
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   input  pcis_id_t                awid,
   input  pcis_addr_t              awaddr,
   input  logic                    awvalid,
   output logic                    awready,

   input  pcis_data_t              wdata,
   input  logic [`PCIS_STRB_W-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,

   output pcis_id_t                bid,
   output pcis_resp_t              bresp,
   output logic                    bvalid,
   input  logic                    bready,

   input  pcis_id_t                arid,
   input  pcis_addr_t              araddr,
   input  logic                    arvalid,
   output logic                    arready,

   output pcis_id_t                rid,
   output pcis_data_t              rdata,
   output pcis_resp_t              rresp,
   output logic                    rlast,
   output logic                    rvalid,
   input  logic                    rready
);

   logic       capture;
   pcis_addr_t wr_addr;
   pcis_addr_t rd_addr;
   cfg_data_t  wr_word;
   cfg_data_t  rd_word;

   // Config bus
   cfg_cmd_t   cfg_cmd;
   cfg_addr_t  cfg_addr;
   cfg_data_t  cfg_wdata;
   logic       cfg_ack;
   cfg_data_t  cfg_rdata;

   // Single beat only
   assign rlast = 1'b1;

   // --------------------------------------------------------------------
   // Request capture
   // --------------------------------------------------------------------
   pcis_wr_capture i_wr_capture (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .capture    (capture),
      .awaddr     (awaddr),
      .awid       (awid),
      .wdata      (wdata),
      .wr_addr    (wr_addr),
      .wr_id      (bid),
      .wr_word    (wr_word)
   );

   pcis_rd_capture i_rd_capture (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .capture    (capture),
      .araddr     (araddr),
      .arid       (arid),
      .rd_word    (rd_word),
      .rd_addr    (rd_addr),
      .rd_id      (rid),
      .rdata      (rdata)
   );

   // --------------------------------------------------------------------
   // Slave controller and register
   // --------------------------------------------------------------------
   pcis_slave_fsm i_slave_fsm (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awvalid    (awvalid),
      .wvalid     (wvalid),
      .bready     (bready),
      .arvalid    (arvalid),
      .rready     (rready),
      .wr_addr    (wr_addr),
      .rd_addr    (rd_addr),
      .wr_word    (wr_word),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata),
      .capture    (capture),
      .awready    (awready),
      .wready     (wready),
      .arready    (arready),
      .bvalid     (bvalid),
      .rvalid     (rvalid),
      .bresp      (bresp),
      .rresp      (rresp),
      .rd_word    (rd_word),
      .cfg_wdata  (cfg_wdata),
      .cfg_cmd    (cfg_cmd),
      .cfg_addr   (cfg_addr)
   );

   cfg_reg_block i_cfg_reg_block (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_cmd    (cfg_cmd),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata)
   );

endmodule

/* tb_clk_gen.sv */
/*
   Clock and reset for the testbench
   Reset is released on a rising edge after RST_CYCLES cycles
*/
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int CLK_PERIOD = 20,
   parameter int RST_CYCLES = 8
)
(
   output logic clk,
   output logic sync_rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      sync_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      sync_rst_n <= 1'b1;
   end

endmodule

/* tb_cl_hello_world.sv */
/*
   Testbench for the hello-world PCIe slave port
   Fixed-seed random stimulus, one access at a time except the priority test
   Outputs are sampled on the falling edge; the run stops at the first error
*/
`timescale 1ns/1ps
`include "hello_config.svh"

module tb_cl_hello_world
   import pcis_pkg::*, cfg_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int RST_CYCLES   = 8;
   localparam int N_REV        = 4;
   localparam int N_BAD        = 8;
   localparam int N_LANE       = 6;
   localparam int N_PRIO       = 2;
   localparam int N_BP         = 4;
   localparam int N_ACCESS     = 1 + 2*N_REV + N_BAD + 2*N_LANE + 2*N_PRIO + 2*N_BP;
   localparam int LIMIT_CYCLES = N_ACCESS * 200 + RST_CYCLES;

   logic                    clk;
   logic                    sync_rst_n;
   pcis_id_t                awid;
   pcis_addr_t              awaddr;
   logic                    awvalid;
   logic                    awready;
   pcis_data_t              wdata;
   logic [`PCIS_STRB_W-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   pcis_id_t                bid;
   pcis_resp_t              bresp;
   logic                    bvalid;
   logic                    bready;
   pcis_id_t                arid;
   pcis_addr_t              araddr;
   logic                    arvalid;
   logic                    arready;
   pcis_id_t                rid;
   pcis_data_t              rdata;
   pcis_resp_t              rresp;
   logic                    rlast;
   logic                    rvalid;
   logic                    rready;

   // Expected content of the hello-world register
   cfg_data_t ref_reg;

   tb_clk_gen #(
      .CLK_PERIOD (CLK_PERIOD),
      .RST_CYCLES (RST_CYCLES)
   ) i_clk_gen (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   cl_hello_world i_dut (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .awid       (awid),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bid        (bid),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .arid       (arid),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rid        (rid),
      .rdata      (rdata),
      .rresp      (rresp),
      .rlast      (rlast),
      .rvalid     (rvalid),
      .rready     (rready)
   );

   // ----------------------------------------------------------------------
   // Failure reporting
   // ----------------------------------------------------------------------
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      stop_with_failure($sformatf("Mismatch at %0d ns: %s", $time, msg));
   endtask

   // ----------------------------------------------------------------------
   // Protocol checks
   // ----------------------------------------------------------------------
   b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
      else report_mismatch("write response changed while bready was low");

   r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata))
      else report_mismatch("read response changed while rready was low");

   // Nothing new is accepted while a response is pending
   no_ready: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (bvalid || rvalid) |-> !awready && !wready && !arready)
      else report_mismatch("ready asserted while a response was pending");

   one_resp: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(bvalid && rvalid))
      else report_mismatch("bvalid and rvalid high together");

   last_beat: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rvalid |-> rlast && (rresp == RESP_OKAY))
      else report_mismatch("rlast low or rresp not OKAY");

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic int lane_of(input pcis_addr_t addr);
      return int'(addr[`LANE_SEL_MSB:`LANE_SEL_LSB]);
   endfunction

   function automatic pcis_data_t random_data();
      pcis_data_t d;
      for (int i = 0; i < `PCIS_DATA_W / `CFG_DATA_W; i++)
         d[i*`CFG_DATA_W +: `CFG_DATA_W] = $urandom;
      return d;
   endfunction

   // Any write address updates the register
   function automatic void model_write(input pcis_addr_t addr, input pcis_data_t data);
      ref_reg = cfg_data_t'(data >> (`CFG_DATA_W * lane_of(addr)));
   endfunction

   function automatic pcis_data_t expected_rdata(input pcis_addr_t addr);
      cfg_data_t word;
      if (addr[`CFG_ADDR_W-1:0] == `HELLO_ADDR)
         word = {<<8{ref_reg}};
      else
         word = `CFG_BAD_RDATA;
      return pcis_data_t'(word) << (`CFG_DATA_W * lane_of(addr));
   endfunction

   task automatic check_read(input pcis_addr_t addr, input pcis_data_t got);
      pcis_data_t exp;
      exp = expected_rdata(addr);
      assert (got === exp)
      else report_mismatch($sformatf("read at %0h gave %0h, expected %0h", addr, got, exp));
   endtask

   // ----------------------------------------------------------------------
   // Bus handshakes
   // ----------------------------------------------------------------------
   task automatic init_inputs();
      awid    = '0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arid    = '0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
   endtask

   task automatic write_access(input pcis_addr_t addr, input pcis_data_t data,
                               input pcis_id_t id, input int stall, output time seen_at);
      bit aw_done;
      bit w_done;
      bit aw_hs;
      bit w_hs;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk);
      awaddr  <= addr;
      awid    <= id;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= '1;
      wvalid  <= 1'b1;
      bready  <= (stall == 0);
      while (!(aw_done && w_done))
      begin
         @(negedge clk);
         aw_hs = awvalid && awready;
         w_hs  = wvalid && wready;
         @(posedge clk);
         if (aw_hs)
         begin
            awvalid <= 1'b0;
            aw_done = 1'b1;
         end
         if (w_hs)
         begin
            wvalid <= 1'b0;
            w_done = 1'b1;
         end
      end
      do
         @(negedge clk);
      while (!bvalid);
      seen_at = $time;
      assert (bid == id && bresp == RESP_OKAY)
      else report_mismatch($sformatf("bid %0h bresp %0d, expected %0h OKAY", bid, bresp, id));
      if (stall > 0)
      begin
         repeat (stall)
         begin
            @(negedge clk);
            assert (bvalid && bid == id)
            else report_mismatch("bvalid dropped or bid changed under back-pressure");
         end
         @(posedge clk);
         bready <= 1'b1;
         @(negedge clk);
      end
      @(posedge clk);
      bready <= 1'b0;
      model_write(addr, data);
   endtask

   task automatic read_access(input pcis_addr_t addr, input pcis_id_t id, input int stall,
                              output pcis_data_t data, output time seen_at);
      bit ar_hs;
      ar_hs = 1'b0;
      @(posedge clk);
      araddr  <= addr;
      arid    <= id;
      arvalid <= 1'b1;
      rready  <= (stall == 0);
      while (!ar_hs)
      begin
         @(negedge clk);
         ar_hs = arready;
         @(posedge clk);
      end
      arvalid <= 1'b0;
      do
         @(negedge clk);
      while (!rvalid);
      seen_at = $time;
      data    = rdata;
      assert (rid == id)
      else report_mismatch($sformatf("rid %0h, expected %0h", rid, id));
      if (stall > 0)
      begin
         repeat (stall)
         begin
            @(negedge clk);
            assert (rvalid && rid == id && rdata == data)
            else report_mismatch("read response changed under back-pressure");
         end
         @(posedge clk);
         rready <= 1'b1;
         @(negedge clk);
      end
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic reset_state_test();
      pcis_data_t got;
      time        t;
      while (sync_rst_n !== 1'b1)
         @(posedge clk);
      @(negedge clk);
      assert (!awready && !wready && !arready && !bvalid && !rvalid && !i_dut.cfg_ack)
      else report_mismatch("handshake outputs not low after reset");
      read_access('0, pcis_id_t'($urandom), 0, got, t);
      check_read('0, got);
   endtask

   task automatic byte_reversal_test();
      pcis_data_t got;
      time        t;
      repeat (N_REV)
      begin
         write_access('0, random_data(), pcis_id_t'($urandom), 0, t);
         read_access('0, pcis_id_t'($urandom), 0, got, t);
         check_read('0, got);
      end
   endtask

   task automatic unmapped_read_test();
      pcis_addr_t addr;
      pcis_data_t got;
      time        t;
      repeat (N_BAD)
      begin
         addr = pcis_addr_t'($urandom_range(255, 1));
         read_access(addr, pcis_id_t'($urandom), 0, got, t);
         check_read(addr, got);
      end
   endtask

   // Junk in every lane but the addressed one matters only through the model
   task automatic lane_select_test();
      pcis_addr_t addr;
      pcis_data_t got;
      time        t;
      repeat (N_LANE)
      begin
         addr = pcis_addr_t'(4 * $urandom_range(15, 0));
         write_access(addr, random_data(), pcis_id_t'($urandom), 0, t);
         read_access('0, pcis_id_t'($urandom), 0, got, t);
         check_read('0, got);
      end
   endtask

   task automatic write_priority_test();
      pcis_addr_t addr;
      pcis_data_t data;
      pcis_data_t got;
      time        b_seen;
      time        r_seen;
      int         stall;
      repeat (N_PRIO)
      begin
         addr  = pcis_addr_t'(4 * $urandom_range(15, 0));
         data  = random_data();
         stall = $urandom_range(6, 1);
         fork
            write_access(addr, data, pcis_id_t'($urandom), stall, b_seen);
            read_access('0, pcis_id_t'($urandom), 0, got, r_seen);
         join
         assert (b_seen < r_seen)
         else report_mismatch("read answered before the concurrent write");
         check_read('0, got);
      end
   endtask

   task automatic backpressure_test();
      pcis_addr_t addr;
      pcis_data_t got;
      time        t;
      repeat (N_BP)
      begin
         addr = pcis_addr_t'($urandom_range(255, 0));
         write_access(addr, random_data(), pcis_id_t'($urandom), $urandom_range(12, 1), t);
         addr = pcis_addr_t'($urandom_range(255, 0));
         read_access(addr, pcis_id_t'($urandom), $urandom_range(12, 1), got, t);
         check_read(addr, got);
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------------------------------------
   initial
   begin : main
      void'($urandom(32'h3393));
      init_inputs();
      ref_reg = `HELLO_RST_VAL;
      reset_state_test();
      byte_reversal_test();
      unmapped_read_test();
      lane_select_test();
      write_priority_test();
      backpressure_test();
      repeat (2) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
   end

   initial
   begin : watchdog
      repeat (LIMIT_CYCLES) @(posedge clk);
      stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                  LIMIT_CYCLES));
   end

endmodule

/* compile.f */
+incdir+.
pcis_pkg.sv
cfg_pkg.sv
pcis_wr_capture.sv
pcis_rd_capture.sv
pcis_slave_fsm.sv
cfg_reg_block.sv
cl_hello_world.sv
tb_clk_gen.sv
tb_cl_hello_world.sv

/* run.sh */
#!/bin/sh
# Build and run the hello-world testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_cl_hello_world -f compile.f -o sim_hello \
   && ./obj_dir/sim_hello > sim.log 2>&1 \
   || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "RESULT: PASS" \
   || { echo "RESULT: FAIL"; exit 1; }
